//--- verilog/tree_defs.svh
`ifndef TREE_DEFS_SVH
`define TREE_DEFS_SVH

`define TREE_FEAT_W 10
`define TREE_NUM_FEATS 64
`define TREE_FIDX_W 6
`define TREE_NUM_NODES 64
`define TREE_NODE_W 6
`define TREE_NUM_CLASSES 5
`define TREE_MAX_DEPTH 16

// A child pointer is a node index plus one leaf flag on top.
`define TREE_PTR_W (`TREE_NODE_W + 1)
`define TREE_ENTRY_W (`TREE_FIDX_W + `TREE_FEAT_W + 2 * `TREE_PTR_W)

`define TREE_RIGHT_LSB 0
`define TREE_LEFT_LSB `TREE_PTR_W
`define TREE_THR_LSB (2 * `TREE_PTR_W)
`define TREE_FIDX_LSB (`TREE_THR_LSB + `TREE_FEAT_W)

`endif

//--- verilog/tree_pkg.sv
`include "tree_defs.svh"

package tree_pkg;

	typedef logic [`TREE_FEAT_W-1:0] feat_t; // One feature value.

	typedef logic [`TREE_FIDX_W-1:0] feat_idx_t; // Feature slot index.

	typedef logic [`TREE_NODE_W-1:0] node_idx_t; // Node table address.

	// Top bit set marks a leaf; the low bits then hold the class number.
	typedef logic [`TREE_PTR_W-1:0] child_ptr_t;

	// Feature index, threshold, left child, right child, top down.
	typedef logic [`TREE_ENTRY_W-1:0] node_entry_t;

	typedef logic [`TREE_NUM_NODES-1:0] cmp_vec_t; // One comparison bit per node.

	typedef logic [`TREE_NUM_CLASSES-1:0] decision_t; // One-hot class.

endpackage

//--- verilog/feature_bank.sv
`timescale 1ns/1ps

`include "tree_defs.svh"

module feature_bank (
	input logic clk,
	input logic arst_n,
	input logic feat_wr,
	input tree_pkg::feat_idx_t feat_idx,
	input tree_pkg::feat_t feat_value,
	output tree_pkg::feat_t feats [`TREE_NUM_FEATS]
);

	// One register per feature slot, written one value per strobe.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `TREE_NUM_FEATS; i++) begin
				feats[i] <= '0; // Unwritten features read as zero.
			end
		end else if (feat_wr) begin
			feats[feat_idx] <= feat_value;
		end
	end

endmodule

//--- verilog/node_table.sv
`timescale 1ns/1ps

`include "tree_defs.svh"

module node_table (
	input logic clk,
	input logic arst_n,
	input logic node_wr,
	input tree_pkg::node_idx_t node_addr,
	input tree_pkg::node_entry_t node_data,
	output tree_pkg::node_entry_t nodes [`TREE_NUM_NODES]
);

	// The whole table is visible at once. The comparator bank reads the
	// feature and threshold fields, the resolver reads the child fields.
	// Writes during a classification in flight give a mixed tree.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `TREE_NUM_NODES; i++) begin
				nodes[i] <= '0; // All-zero entry loops node 0 onto itself.
			end
		end else if (node_wr) begin
			nodes[node_addr] <= node_data;
		end
	end

endmodule

//--- verilog/node_comparator_bank.sv
`timescale 1ns/1ps

`include "tree_defs.svh"

module node_comparator_bank (
	input logic clk,
	input logic arst_n,
	input logic classify,
	input tree_pkg::feat_t feats [`TREE_NUM_FEATS],
	input tree_pkg::node_entry_t nodes [`TREE_NUM_NODES],
	output tree_pkg::cmp_vec_t cmp_bits,
	output logic cmp_valid
);

	tree_pkg::cmp_vec_t le_bits;

	// Every node compares its own feature against its threshold in parallel.
	for (genvar n = 0; n < `TREE_NUM_NODES; n++) begin : g_node
		tree_pkg::feat_idx_t fidx;
		tree_pkg::feat_t thr;
		tree_pkg::feat_t sel;

		assign fidx = nodes[n][`TREE_FIDX_LSB +: `TREE_FIDX_W];
		assign thr = nodes[n][`TREE_THR_LSB +: `TREE_FEAT_W];
		assign sel = feats[fidx];
		assign le_bits[n] = (sel <= thr); // Set bit steers the walk left.
	end

	// Snapshot of the comparisons taken on the classify edge.
	always_ff @(posedge clk) begin
		if (classify) begin
			cmp_bits <= le_bits;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cmp_valid <= 1'b0;
		end else begin
			cmp_valid <= classify;
		end
	end

endmodule

//--- verilog/path_resolver.sv
`timescale 1ns/1ps

`include "tree_defs.svh"

module path_resolver (
	input logic clk,
	input logic arst_n,
	input tree_pkg::cmp_vec_t cmp_bits,
	input logic cmp_valid,
	input tree_pkg::node_entry_t nodes [`TREE_NUM_NODES],
	output tree_pkg::decision_t decision,
	output logic result_valid
);

	tree_pkg::decision_t walk_dec;

	// Unrolled walk from the root. Each step picks one child of the current
	// node; the first leaf ends the walk. Without a leaf the result stays zero.
	always_comb begin
		tree_pkg::node_idx_t cur;
		tree_pkg::child_ptr_t ptr;
		tree_pkg::node_idx_t leaf_cls;
		logic done;

		cur = '0;
		ptr = '0;
		leaf_cls = '0;
		done = 1'b0;
		walk_dec = '0;
		for (int step = 0; step < `TREE_MAX_DEPTH; step++) begin
			if (!done) begin
				if (cmp_bits[cur]) begin
					ptr = nodes[cur][`TREE_LEFT_LSB +: `TREE_PTR_W];
				end else begin
					ptr = nodes[cur][`TREE_RIGHT_LSB +: `TREE_PTR_W];
				end
				if (ptr[`TREE_NODE_W]) begin
					done = 1'b1;
					leaf_cls = ptr[`TREE_NODE_W-1:0];
					if (leaf_cls < `TREE_NUM_CLASSES) begin
						walk_dec = tree_pkg::decision_t'(1) << leaf_cls;
					end // Out-of-range class numbers decode to no class.
				end else begin
					cur = ptr[`TREE_NODE_W-1:0];
				end
			end
		end
	end

	// Decision holds until the next result is loaded.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			decision <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= cmp_valid;
			if (cmp_valid) begin
				decision <= walk_dec;
			end
		end
	end

endmodule

//--- verilog/tree_classifier.sv
`timescale 1ns/1ps

`include "tree_defs.svh"

module tree_classifier (
	input logic clk,
	input logic arst_n,
	input logic feat_wr,
	input tree_pkg::feat_idx_t feat_idx,
	input tree_pkg::feat_t feat_value,
	input logic node_wr,
	input tree_pkg::node_idx_t node_addr,
	input tree_pkg::node_entry_t node_data,
	input logic classify,
	output tree_pkg::decision_t decision,
	output logic result_valid
);

	tree_pkg::feat_t feats [`TREE_NUM_FEATS];
	tree_pkg::node_entry_t nodes [`TREE_NUM_NODES];
	tree_pkg::cmp_vec_t cmp_bits;
	logic cmp_valid;

	feature_bank feature_bank_i (
		.clk(clk),
		.arst_n(arst_n),
		.feat_wr(feat_wr),
		.feat_idx(feat_idx),
		.feat_value(feat_value),
		.feats(feats)
	);

	node_table node_table_i (
		.clk(clk),
		.arst_n(arst_n),
		.node_wr(node_wr),
		.node_addr(node_addr),
		.node_data(node_data),
		.nodes(nodes)
	);

	// First pipeline stage. All node tests in one cycle.
	node_comparator_bank node_comparator_bank_i (
		.clk(clk),
		.arst_n(arst_n),
		.classify(classify),
		.feats(feats),
		.nodes(nodes),
		.cmp_bits(cmp_bits),
		.cmp_valid(cmp_valid)
	);

	// Second stage. The child pointers come straight from the table.
	path_resolver path_resolver_i (
		.clk(clk),
		.arst_n(arst_n),
		.cmp_bits(cmp_bits),
		.cmp_valid(cmp_valid),
		.nodes(nodes),
		.decision(decision),
		.result_valid(result_valid)
	);

endmodule

//--- tests/tree_classifier_assert.sv
`timescale 1ns/1ps

module tree_classifier_assert (
	input logic clk,
	input logic arst_n,
	input logic classify,
	input tree_pkg::decision_t decision,
	input logic result_valid
);

	// Every classify gives a result two sampled edges later.
	assert property (@(posedge clk) disable iff (!arst_n)
		classify |-> ##2 result_valid)
	else $error("result_valid missing two cycles after classify");

	// No result appears without a classify behind it.
	assert property (@(posedge clk) disable iff (!arst_n)
		result_valid |-> $past(classify, 2))
	else $error("result_valid without a matching classify");

	assert property (@(posedge clk) $onehot0(decision))
	else $error("decision has more than one bit set");

	assert property (@(posedge clk) !arst_n |-> !result_valid)
	else $error("result_valid high during reset");

endmodule

bind tree_classifier tree_classifier_assert tree_classifier_assert_i (
	.clk(clk),
	.arst_n(arst_n),
	.classify(classify),
	.decision(decision),
	.result_valid(result_valid)
);

//--- tests/tree_classifier_tb.sv
`timescale 1ns/1ps

`include "tree_defs.svh"

module tree_classifier_tb;

	localparam int CLK_PERIOD = 100;
	localparam int PTR_W = `TREE_NODE_W + 1;
	localparam int RIGHT_LSB = 0;
	localparam int LEFT_LSB = PTR_W;
	localparam int THR_LSB = 2 * PTR_W;
	localparam int FIDX_LSB = THR_LSB + `TREE_FEAT_W;
	localparam int USED_FEATS = 8; // The reference tree only tests features 0 to 7.
	localparam int RANDOM_RUNS = 200;
	localparam int B2B_RUNS = 20;
	localparam int MAX_WAIT = 8;

	// Cycle budget per test, summed for the watchdog.
	localparam int LOAD_CYCLES = 2 * `TREE_NUM_NODES;
	localparam int CLASSIFY_CYCLES = 3 + MAX_WAIT;
	localparam int RESET_TEST_CYCLES = 4 + LOAD_CYCLES + CLASSIFY_CYCLES;
	localparam int RANDOM_TEST_CYCLES = RANDOM_RUNS * (USED_FEATS + 1 + CLASSIFY_CYCLES);
	localparam int B2B_TEST_CYCLES = B2B_RUNS * (3 + MAX_WAIT);
	localparam int SMALL_TEST_CYCLES = 5 * (2 + 2 + CLASSIFY_CYCLES);
	localparam int BUDGET_CYCLES = RESET_TEST_CYCLES + RANDOM_TEST_CYCLES + B2B_TEST_CYCLES
		+ SMALL_TEST_CYCLES + 1000;

	logic clk;
	logic arst_n;
	logic feat_wr;
	tree_pkg::feat_idx_t feat_idx;
	tree_pkg::feat_t feat_value;
	logic node_wr;
	tree_pkg::node_idx_t node_addr;
	tree_pkg::node_entry_t node_data;
	logic classify;
	tree_pkg::decision_t decision;
	logic result_valid;

	tree_pkg::node_entry_t ref_tree [`TREE_NUM_NODES];
	tree_pkg::node_entry_t tb_nodes [`TREE_NUM_NODES]; // Mirror of the DUT node table.
	tree_pkg::feat_t tb_feats [`TREE_NUM_FEATS]; // Mirror of the DUT feature bank.
	int errors;
	int tests_run;
	int tests_failed;

	tree_classifier tree_classifier_i (
		.clk(clk),
		.arst_n(arst_n),
		.feat_wr(feat_wr),
		.feat_idx(feat_idx),
		.feat_value(feat_value),
		.node_wr(node_wr),
		.node_addr(node_addr),
		.node_data(node_data),
		.classify(classify),
		.decision(decision),
		.result_valid(result_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(BUDGET_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests completed.");
		$display("TEST FAILED");
		$finish;
	end

	function automatic tree_pkg::decision_t model_walk();
		int cur;
		int cls;
		tree_pkg::node_entry_t e;
		tree_pkg::feat_idx_t fid;
		tree_pkg::feat_t thr;
		tree_pkg::child_ptr_t ptr;
		tree_pkg::decision_t res;

		cur = 0;
		res = '0;
		for (int step = 0; step < `TREE_MAX_DEPTH; step++) begin
			e = tb_nodes[cur];
			fid = e[FIDX_LSB +: `TREE_FIDX_W];
			thr = e[THR_LSB +: `TREE_FEAT_W];
			if (tb_feats[fid] <= thr) begin
				ptr = e[LEFT_LSB +: PTR_W];
			end else begin
				ptr = e[RIGHT_LSB +: PTR_W];
			end
			if (ptr[PTR_W-1]) begin
				cls = int'(ptr[PTR_W-2:0]);
				if (cls < `TREE_NUM_CLASSES) begin
					res[cls] = 1'b1;
				end
				return res;
			end
			cur = int'(ptr[PTR_W-2:0]);
		end
		return res; // No leaf reached within the depth limit.
	endfunction

	task automatic check_decision(input string name, input tree_pkg::decision_t exp,
			input tree_pkg::decision_t act);
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s decision expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_valid(input string name, input bit exp, input bit act);
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s result_valid expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic write_node(input int addr, input tree_pkg::node_entry_t data);
		@(posedge clk);
		node_wr <= 1'b1;
		node_addr <= tree_pkg::node_idx_t'(addr);
		node_data <= data;
		@(posedge clk);
		node_wr <= 1'b0;
		tb_nodes[addr] = data;
	endtask

	task automatic write_feat(input int idx, input tree_pkg::feat_t value);
		@(posedge clk);
		feat_wr <= 1'b1;
		feat_idx <= tree_pkg::feat_idx_t'(idx);
		feat_value <= value;
		@(posedge clk);
		feat_wr <= 1'b0;
		tb_feats[idx] = value;
	endtask

	task automatic load_tree();
		$readmemh("tests/reference_tree.mem", ref_tree);
		for (int i = 0; i < `TREE_NUM_NODES; i++) begin
			write_node(i, ref_tree[i]);
		end
	endtask

	// Waits for result_valid on falling edges; the count starts at the classify edge.
	task automatic wait_result(input string name, output int waited);
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!result_valid && waited < MAX_WAIT);
		if (!result_valid) begin
			errors++;
			$display("%s: result_valid never came after classify.", name);
		end else if (waited != 2) begin
			errors++;
			$display("%s: result came after %0d cycles instead of 2.", name, waited);
		end
	endtask

	task automatic classify_and_check(input string name, input tree_pkg::decision_t exp);
		int waited;

		@(posedge clk);
		classify <= 1'b1;
		@(posedge clk);
		classify <= 1'b0;
		wait_result(name, waited);
		check_decision(name, exp, decision);
		// The pulse is one cycle wide and the decision stays put after it.
		@(negedge clk);
		check_valid(name, 1'b0, result_valid);
		check_decision(name, exp, decision);
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - err_before);
		end
	endtask

	task automatic test_reset_state();
		int err_before;

		err_before = errors;
		@(negedge clk);
		check_valid("reset_state", 1'b0, result_valid);
		check_decision("reset_state", '0, decision);
		load_tree();
		classify_and_check("reset_state", model_walk()); // All features still zero.
		finish_test("reset_state", err_before);
	endtask

	task automatic test_random();
		int err_before;

		err_before = errors;
		for (int r = 0; r < RANDOM_RUNS; r++) begin
			for (int i = 0; i < USED_FEATS; i++) begin
				write_feat(i, tree_pkg::feat_t'($urandom_range(0, 1023)));
			end
			classify_and_check("random", model_walk());
		end
		finish_test("random", err_before);
	endtask

	task automatic test_back_to_back();
		int err_before;
		int waited;
		int got;
		tree_pkg::decision_t exp_q [$];
		tree_pkg::feat_t value;

		err_before = errors;
		for (int r = 0; r < B2B_RUNS; r++) begin
			value = tree_pkg::feat_t'($urandom_range(0, 1023));
			@(posedge clk);
			classify <= 1'b1;
			feat_wr <= 1'b1; // Lands on the same edge as the first classify.
			feat_idx <= '0;
			feat_value <= value;
			exp_q.push_back(model_walk());
			@(posedge clk);
			feat_wr <= 1'b0;
			tb_feats[0] = value;
			exp_q.push_back(model_walk());
			@(posedge clk);
			classify <= 1'b0;
			got = 0;
			waited = 0;
			while (got < 2 && waited < MAX_WAIT) begin
				@(negedge clk);
				waited++;
				if (result_valid) begin
					check_decision("back_to_back", exp_q.pop_front(), decision);
					got++;
				end
			end
			if (got != 2) begin
				errors++;
				$display("back_to_back: only %0d of 2 results arrived.", got);
				exp_q.delete();
			end
		end
		finish_test("back_to_back", err_before);
	endtask

	task automatic test_threshold_edge();
		int err_before;

		err_before = errors;
		// Node 0 tests feature 3 against 500, leaf class 1 left and class 4 right.
		write_node(0, {6'd3, 10'd500, 7'h41, 7'h44});
		write_feat(3, 10'd500);
		classify_and_check("threshold_edge", 5'b00010);
		write_feat(3, 10'd501);
		classify_and_check("threshold_edge", 5'b10000);
		finish_test("threshold_edge", err_before);
	endtask

	task automatic test_bad_walks();
		int err_before;

		err_before = errors;
		write_node(0, {6'd0, 10'd0, 7'h00, 7'h00}); // Root loops onto itself.
		classify_and_check("bad_walks", '0);
		write_node(0, {6'd0, 10'd0, 7'h42, 7'h42}); // A valid leaf sets a class first.
		classify_and_check("bad_walks", 5'b00100);
		write_node(0, {6'd0, 10'd0, 7'h46, 7'h46}); // Class 6 is out of range.
		classify_and_check("bad_walks", '0);
		finish_test("bad_walks", err_before);
	endtask

	initial begin
		arst_n = 1'b0;
		feat_wr = 1'b0;
		feat_idx = '0;
		feat_value = '0;
		node_wr = 1'b0;
		node_addr = '0;
		node_data = '0;
		classify = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int i = 0; i < `TREE_NUM_FEATS; i++) begin
			tb_feats[i] = '0;
		end
		for (int i = 0; i < `TREE_NUM_NODES; i++) begin
			tb_nodes[i] = '0;
		end
		void'($urandom(32'hf0d85dfc));
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;

		test_reset_state();
		test_random();
		test_back_to_back();
		test_threshold_edge();
		test_bad_walks();

		$display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- tests/reference_tree.mem
// One node per line: fidx[29:24] threshold[23:14] left[13:7] right[6:0], hex.
// Child bit 6 set marks a leaf with the class in the low bits; nodes 43 to 63 unused.
00200082
01400184
02600286
03800388
04A0048A
05C0058C
06E0068E
07200790
00400892
01600994
02800A96
03A00B98
04C00C9A
05E00D9C
06200E9E
07400FA0
006010A2
018011A4
02A012A6
03C013A8
04E014AA
05202143
06402240
076020C2
008021C4
01A02041
02C02143
03E02240
042020C2
054021C4
06602041
07802143
00A02240
01C020C2
02E021C4
03202041
04402143
05602240
068020C2
07A021C4
00C02041
01E02143
02202240
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000

//--- flist.f
+incdir+verilog
verilog/tree_pkg.sv
verilog/feature_bank.sv
verilog/node_table.sv
verilog/node_comparator_bank.sv
verilog/path_resolver.sv
verilog/tree_classifier.sv
tests/tree_classifier_assert.sv
tests/tree_classifier_tb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the tree classifier testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tree_classifier_tb -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "TEST OK" sim.log; then
	exit 0
fi
exit 1
